/* filelist.f */
hdl/rv_lite_pkg.sv
hdl/riscv_regfile.sv
hdl/issue_ctrl.sv
hdl/alu_unit.sv
hdl/lsu_unit.sv
hdl/wb_arbiter.sv
hdl/rv_lite_top.sv
tb/tb_rv_lite.sv

/* hdl/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_lite_pkg::alu_req_t alu_req,
  input  logic                 alu_go,
  input  logic                 alu_grant,
  output rv_lite_pkg::wb_req_t  alu_wb,
  output logic                 alu_wb_valid,
  output logic                 alu_busy
);

  import rv_lite_pkg::*;

  word_t result;
  logic [4:0] shamt;

  assign shamt = alu_req.b[4:0];

  always_comb
  begin
    case (alu_req.op)
      alu_add: result = alu_req.a + alu_req.b;
      alu_sub: result = alu_req.a - alu_req.b;
      alu_sll: result = alu_req.a << shamt;
      alu_slt: result = word_t'($signed(alu_req.a) < $signed(alu_req.b));
      alu_sltu: result = word_t'(alu_req.a < alu_req.b);
      alu_xor: result = alu_req.a ^ alu_req.b;
      alu_srl: result = alu_req.a >> shamt;
      alu_sra: result = word_t'($signed(alu_req.a) >>> shamt);
      alu_or: result = alu_req.a | alu_req.b;
      alu_and: result = alu_req.a & alu_req.b;
      alu_pass_b: result = alu_req.b;  // LUI
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      alu_wb_valid <= 1'b0;
    else if (alu_go)
      alu_wb_valid <= 1'b1;
    else if (alu_grant)
      alu_wb_valid <= 1'b0;
  end

  // Result stays put until the arbiter takes it
  always_ff @(posedge clk)
  begin
    if (alu_go)
    begin
      alu_wb.rd <= alu_req.rd;
      alu_wb.data <= result;
    end
  end

  assign alu_busy = alu_wb_valid;

  // The issue side must hold back while a result waits for the write port
  assert property (@(posedge clk) disable iff (rst) alu_go |-> !alu_busy)
    else $error("ALU dispatch while a result is still waiting");

endmodule

/* hdl/issue_ctrl.sv */
`timescale 1ns/100ps

module issue_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_lite_pkg::word_t     instr,
  input  logic                  instr_valid,
  input  rv_lite_pkg::reg_bank_t x,
  input  rv_lite_pkg::reg_mask_t x_wr,
  input  logic                  alu_busy,
  input  logic                  lsu_busy,
  output rv_lite_pkg::alu_req_t  alu_req,
  output logic                  alu_go,
  output rv_lite_pkg::lsu_req_t  lsu_req,
  output logic                  lsu_go,
  output logic                  stall,
  output logic                  illegal
);

  import rv_lite_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t rs1_val;
  word_t rs2_val;
  word_t addr_sum;
  logic is_alu;
  logic is_lsu;
  logic is_store;
  logic legal;
  logic use_rs1;
  logic use_rs2;
  logic use_rd;
  logic hazard;
  logic unit_blocked;
  logic take;
  alu_op_e alu_op;
  reg_mask_t pending;
  reg_mask_t need_mask;
  reg_mask_t set_mask;

  assign opcode = instr[6:0];
  assign rd = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign rs1_val = x[rs1];
  assign rs2_val = x[rs2];
  assign is_store = (opcode == OPC_STORE);
  assign addr_sum = rs1_val + (is_store ? imm_s : imm_i);

  always_comb
  begin
    is_alu = 1'b0;
    is_lsu = 1'b0;
    legal = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd = 1'b0;
    case (opcode)
      OPC_OP:
      begin
        is_alu = 1'b1;
        {use_rs1, use_rs2, use_rd} = 3'b111;
        legal = (funct7 == F7_BASE) ||
                (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
      end
      OPC_OP_IMM:
      begin
        is_alu = 1'b1;
        {use_rs1, use_rd} = 2'b11;
        if (funct3 == F3_SLL)
          legal = (funct7 == F7_BASE);
        else if (funct3 == F3_SR)
          legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        else
          legal = 1'b1;
      end
      OPC_LUI:
      begin
        is_alu = 1'b1;
        use_rd = 1'b1;
        legal = 1'b1;
      end
      OPC_LOAD:
      begin
        is_lsu = 1'b1;
        {use_rs1, use_rd} = 2'b11;
        legal = (funct3 == F3_WORD);
      end
      OPC_STORE:
      begin
        is_lsu = 1'b1;
        {use_rs1, use_rs2} = 2'b11;
        legal = (funct3 == F3_WORD);
      end
      default:
        legal = 1'b0;
    endcase
  end

  always_comb
  begin
    case (funct3)
      F3_ADD: alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ? alu_sub : alu_add;
      F3_SLL: alu_op = alu_sll;
      F3_SLT: alu_op = alu_slt;
      F3_SLTU: alu_op = alu_sltu;
      F3_XOR: alu_op = alu_xor;
      F3_SR: alu_op = (funct7 == F7_ALT) ? alu_sra : alu_srl;
      F3_OR: alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
    if (opcode == OPC_LUI)
      alu_op = alu_pass_b;
  end

  always_comb
  begin
    need_mask = '0;
    if (use_rs1)
      need_mask[rs1] = 1'b1;
    if (use_rs2)
      need_mask[rs2] = 1'b1;
    if (use_rd)
      need_mask[rd] = 1'b1;  // Keeps writes to one register in order
  end

  // A strobe still in the dispatch register counts as an occupied unit
  assign unit_blocked = (is_alu && (alu_busy || alu_go)) || (is_lsu && (lsu_busy || lsu_go));
  assign hazard = |(need_mask & pending);
  assign stall = instr_valid && legal && (hazard || unit_blocked);
  assign take = instr_valid && !stall;

  always_comb
  begin
    set_mask = '0;
    if (take && legal && use_rd && rd != '0)
      set_mask[rd] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending <= '0;
      alu_go <= 1'b0;
      lsu_go <= 1'b0;
      illegal <= 1'b0;
    end
    else
    begin
      pending <= (pending & ~x_wr) | set_mask;
      alu_go <= take && legal && is_alu;
      lsu_go <= take && legal && is_lsu;
      illegal <= take && !legal;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      alu_req.op <= alu_op;
      alu_req.a <= rs1_val;
      alu_req.b <= (opcode == OPC_OP) ? rs2_val : (opcode == OPC_LUI) ? imm_u : imm_i;
      alu_req.rd <= rd;
      lsu_req.is_store <= is_store;
      lsu_req.addr <= addr_sum[DMEM_AW+1:2];  // Word index, low byte bits dropped
      lsu_req.wdata <= rs2_val;
      lsu_req.rd <= is_store ? '0 : rd;
    end
  end

  // Every register write must retire a destination this controller marked busy
  assert property (@(posedge clk) disable iff (rst) (x_wr & ~pending) == '0)
    else $error("write strobe %h hits a register with no pending result", x_wr);

endmodule

/* hdl/lsu_unit.sv */
`timescale 1ns/100ps

module lsu_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_lite_pkg::lsu_req_t lsu_req,
  input  logic                 lsu_go,
  input  logic                 lsu_grant,
  output rv_lite_pkg::wb_req_t  lsu_wb,
  output logic                 lsu_wb_valid,
  output logic                 lsu_busy,
  output logic                 store_done
);

  import rv_lite_pkg::*;

  lsu_state_e state;
  logic store_q;
  word_t mem [DMEM_WORDS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= lsu_idle;
    end
    else
    begin
      case (state)
        lsu_idle:
        begin
          if (lsu_go)
            state <= lsu_read;
        end
        lsu_read:
        begin
          if (lsu_grant)
            state <= lsu_idle;
          else
            state <= lsu_hold;  // Port taken, keep the data
        end
        lsu_hold:
        begin
          if (lsu_grant)
            state <= lsu_idle;
        end
        default:
          state <= lsu_idle;
      endcase
    end
  end

  // Single-port RAM, the read returns the old word on a store
  always_ff @(posedge clk)
  begin
    if (state == lsu_idle && lsu_go)
    begin
      if (lsu_req.is_store)
        mem[lsu_req.addr] <= lsu_req.wdata;
      lsu_wb.data <= mem[lsu_req.addr];
      lsu_wb.rd <= lsu_req.rd;
      store_q <= lsu_req.is_store;
    end
  end

  // A store claims the port once with rd 0 so its retire never overlaps an ALU write
  assign lsu_wb_valid = (state != lsu_idle);
  assign lsu_busy = lsu_wb_valid;
  assign store_done = lsu_grant && store_q;

  assert property (@(posedge clk) disable iff (rst)
                   (lsu_wb_valid && !lsu_grant) |=> (lsu_wb_valid && $stable(lsu_wb)))
    else $error("LSU dropped or changed a request before its grant");

endmodule

/* hdl/riscv_regfile.sv */
`timescale 1ns/100ps

module riscv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_lite_pkg::reg_mask_t x_wr,
  input  rv_lite_pkg::word_t     x_in,
  output rv_lite_pkg::reg_bank_t x
);

  import rv_lite_pkg::*;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x <= '0;
    end
    else
    begin
      for (int i = 0; i < NREGS; i++)
      begin
        if (x_wr[i])
          x[i] <= x_in;
      end
      x[0] <= '0;  // x0 is hardwired to zero
    end
  end

  // The arbiter owns the single write port, so at most one strobe may be set
  assert property (@(posedge clk) disable iff (rst) $onehot0(x_wr))
    else $error("regfile write strobe is not one-hot: %h", x_wr);

endmodule

/* hdl/rv_lite_pkg.sv */
package rv_lite_pkg;

  localparam int XLEN = 32;
  localparam int NREGS = 32;
  localparam int REG_AW = 5;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW = $clog2(DMEM_WORDS);

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;
  typedef logic [NREGS-1:0] reg_mask_t;
  typedef logic [NREGS-1:0][XLEN-1:0] reg_bank_t;
  typedef logic [DMEM_AW-1:0] dmem_addr_t;

  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;  // LW and SW
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;  // Selects SUB and SRA

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    word_t a;
    word_t b;
    reg_idx_t rd;
  } alu_req_t;

  typedef struct packed {
    logic is_store;
    dmem_addr_t addr;
    word_t wdata;
    reg_idx_t rd;
  } lsu_req_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t data;
  } wb_req_t;

  typedef enum logic [1:0] {lsu_idle, lsu_read, lsu_hold} lsu_state_e;

endpackage

/* hdl/rv_lite_top.sv */
`timescale 1ns/100ps

module rv_lite_top (
  input  logic              clk,
  input  logic              rst,
  input  rv_lite_pkg::word_t instr,
  input  logic              instr_valid,
  input  rv_lite_pkg::reg_idx_t dbg_idx,
  output logic              stall,
  output rv_lite_pkg::word_t dbg_data,
  output logic              retire,
  output logic              illegal
);

  import rv_lite_pkg::*;

  reg_bank_t x;
  reg_mask_t x_wr;
  word_t x_in;
  alu_req_t alu_req;
  lsu_req_t lsu_req;
  wb_req_t alu_wb;
  wb_req_t lsu_wb;
  logic alu_go;
  logic lsu_go;
  logic alu_busy;
  logic lsu_busy;
  logic alu_wb_valid;
  logic lsu_wb_valid;
  logic alu_grant;
  logic lsu_grant;
  logic store_done;

  riscv_regfile regfile_i (
    .clk(clk), .rst(rst), .x_wr(x_wr), .x_in(x_in), .x(x)
  );

  issue_ctrl issue_i (
    .clk(clk), .rst(rst),
    .instr(instr), .instr_valid(instr_valid),
    .x(x), .x_wr(x_wr),
    .alu_busy(alu_busy), .lsu_busy(lsu_busy),
    .alu_req(alu_req), .alu_go(alu_go),
    .lsu_req(lsu_req), .lsu_go(lsu_go),
    .stall(stall), .illegal(illegal)
  );

  alu_unit alu_i (
    .clk(clk), .rst(rst),
    .alu_req(alu_req), .alu_go(alu_go), .alu_grant(alu_grant),
    .alu_wb(alu_wb), .alu_wb_valid(alu_wb_valid), .alu_busy(alu_busy)
  );

  lsu_unit lsu_i (
    .clk(clk), .rst(rst),
    .lsu_req(lsu_req), .lsu_go(lsu_go), .lsu_grant(lsu_grant),
    .lsu_wb(lsu_wb), .lsu_wb_valid(lsu_wb_valid), .lsu_busy(lsu_busy),
    .store_done(store_done)
  );

  wb_arbiter arb_i (
    .alu_wb(alu_wb), .alu_wb_valid(alu_wb_valid),
    .lsu_wb(lsu_wb), .lsu_wb_valid(lsu_wb_valid),
    .alu_grant(alu_grant), .lsu_grant(lsu_grant),
    .x_wr(x_wr), .x_in(x_in)
  );

  assign retire = (|x_wr) || store_done;  // At most one of these per cycle
  assign dbg_data = x[dbg_idx];

endmodule

/* hdl/wb_arbiter.sv */
`timescale 1ns/100ps

module wb_arbiter (
  input  rv_lite_pkg::wb_req_t   alu_wb,
  input  logic                  alu_wb_valid,
  input  rv_lite_pkg::wb_req_t   lsu_wb,
  input  logic                  lsu_wb_valid,
  output logic                  alu_grant,
  output logic                  lsu_grant,
  output rv_lite_pkg::reg_mask_t x_wr,
  output rv_lite_pkg::word_t     x_in
);

  import rv_lite_pkg::*;

  wb_req_t win;

  always_comb
  begin
    lsu_grant = lsu_wb_valid;  // Loads first so the RAM side never stalls long
    alu_grant = alu_wb_valid && !lsu_wb_valid;
    win = lsu_wb_valid ? lsu_wb : alu_wb;
    x_wr = '0;
    if ((lsu_grant || alu_grant) && win.rd != '0)
      x_wr[win.rd] = 1'b1;
    x_in = win.data;
  end

endmodule

/* tb/tb_rv_lite.sv */
`timescale 1ns/100ps

module tb_rv_lite;

  import rv_lite_pkg::*;

  logic clk;
  logic rst;
  word_t instr;
  logic instr_valid;
  reg_idx_t dbg_idx;
  logic stall;
  word_t dbg_data;
  logic retire;
  logic illegal;

  word_t model_x [NREGS];
  word_t model_mem [DMEM_WORDS];
  word_t prog [$];
  dmem_addr_t stored [$];
  logic [31:0] rng_state;
  int retire_count;
  int illegal_count;
  int exp_retire;
  int exp_illegal;
  int error_count;
  int cycle_count;
  int cycle_limit;

  rv_lite_top dut_i (
    .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid), .dbg_idx(dbg_idx),
    .stall(stall), .dbg_data(dbg_data), .retire(retire), .illegal(illegal)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the DUT did not finish the program within %0d cycles", cycle_limit);
      $display("Regression failed");
      $fatal(1);
    end
  end

  // Pulses are counted in the low phase where the DUT outputs are settled
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (retire === 1'b1)
        retire_count++;
      if (illegal === 1'b1)
        illegal_count++;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state = s;
    return s;
  endfunction

  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return {2'b00, r[10:8]};  // x0..x7 keeps sources close to recent results
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t gen_alu(input reg_idx_t rd);
    logic [31:0] r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    r = next_rand();
    f3 = r[2:0];
    imm = r[31:20];
    if (r[5:3] < 3)
    begin
      f7 = ((f3 == F3_ADD || f3 == F3_SR) && r[6]) ? F7_ALT : F7_BASE;
      return enc_r(f7, pick_reg(), pick_reg(), f3, rd, OPC_OP);
    end
    else if (r[5:3] < 6)
    begin
      if (f3 == F3_SLL)
        imm[11:5] = F7_BASE;
      else if (f3 == F3_SR)
        imm[11:5] = r[6] ? F7_ALT : F7_BASE;
      return enc_i(imm, pick_reg(), f3, rd, OPC_OP_IMM);
    end
    return {r[31:12], rd, OPC_LUI};
  endfunction

  function automatic word_t gen_store();
    logic [31:0] r;
    logic [11:0] imm;
    r = next_rand();
    stored.push_back(r[7:0]);
    imm = {2'b00, r[7:0], 2'b00};
    return {imm[11:5], pick_reg(), 5'd0, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  // Loads only touch words that were stored, since the RAM powers up unknown
  function automatic word_t gen_load(input reg_idx_t rd);
    logic [31:0] r;
    dmem_addr_t idx;
    r = next_rand();
    idx = stored[r % stored.size()];
    return enc_i({2'b00, idx, 2'b00}, 5'd0, F3_WORD, rd, OPC_LOAD);
  endfunction

  function automatic word_t gen_bad();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return {r[31:7], 7'b1101111};  // JAL
      3'd1: return {r[31:7], 7'b1100011};  // Branch
      3'd2: return {r[31:7], 7'b1110011};  // SYSTEM
      3'd3: return {r[31:7], 7'b0010111};  // AUIPC
      3'd4: return {r[31:7], 7'b0001111};  // FENCE
      3'd5: return {r[31:7], 7'b1100111};  // JALR
      3'd6: return enc_r(7'b0000001, r[24:20], r[19:15], r[14:12], r[11:7], OPC_OP);
      default: return enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_LOAD);  // LB
    endcase
  endfunction

  function automatic word_t alu_calc(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Returns the retire pulses one instruction gives, or -1 if RV32I-lite rejects it
  function automatic int rv_ref(input word_t w);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t imm_i;
    word_t imm_s;
    word_t addr;
    word_t res;
    opc = w[6:0];
    rd = w[11:7];
    f3 = w[14:12];
    rs1 = w[19:15];
    rs2 = w[24:20];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    case (opc)
      OPC_OP:
      begin
        if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
          return -1;
        res = alu_calc(f3, f7[5], model_x[rs1], model_x[rs2]);
      end
      OPC_OP_IMM:
      begin
        if (f3 == 3'd1 && f7 != 7'h00)
          return -1;
        if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
          return -1;
        res = alu_calc(f3, f3 == 3'd5 && f7[5], model_x[rs1], imm_i);
      end
      OPC_LUI:
        res = {w[31:12], 12'h000};
      OPC_LOAD:
      begin
        if (f3 != 3'b010)
          return -1;
        addr = model_x[rs1] + imm_i;
        res = model_mem[addr[9:2]];
      end
      OPC_STORE:
      begin
        if (f3 != 3'b010)
          return -1;
        addr = model_x[rs1] + imm_s;
        model_mem[addr[9:2]] = model_x[rs2];
        return 1;
      end
      default:
        return -1;
    endcase
    if (rd == 5'd0)
      return 0;
    model_x[rd] = res;
    return 1;
  endfunction

  task add_instr(input word_t w);
    int n;
    n = rv_ref(w);
    if (n < 0)
      exp_illegal++;
    else
      exp_retire += n;
    prog.push_back(w);
  endtask

  task check_value(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      error_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task send_instr(input word_t w);
    @(negedge clk);
    instr = w;
    instr_valid = 1'b1;
    #1;
    while (stall)
    begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);  // Taken on this edge
  endtask

  task check_regs();
    for (int i = 0; i < NREGS; i++)
    begin
      @(negedge clk);
      dbg_idx = reg_idx_t'(i);
      #1;
      check_value(dbg_data, model_x[i], $sformatf("register x%0d", i));
    end
  endtask

  task run_program();
    cycle_limit = cycle_count + prog.size() * 8 + 200;
    foreach (prog[i])
      send_instr(prog[i]);
    @(negedge clk);
    instr_valid = 1'b0;
    while (retire_count != exp_retire)
      @(negedge clk);
    check_regs();
    check_value(retire_count, exp_retire, "retire count");
    check_value(illegal_count, exp_illegal, "illegal count");
    prog.delete();
  endtask

  initial
  begin
    int sel;
    rst = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    dbg_idx = '0;
    rng_state = 32'h3ff06de1;
    retire_count = 0;
    illegal_count = 0;
    exp_retire = 0;
    exp_illegal = 0;
    error_count = 0;
    cycle_count = 0;
    cycle_limit = 8 + 200;
    foreach (model_x[i])
      model_x[i] = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    repeat (4) @(negedge clk);
    check_regs();
    check_value(retire_count, 0, "retire count after reset");
    check_value(illegal_count, 0, "illegal count after reset");

    for (int i = 0; i < 200; i++)
      add_instr(gen_alu(pick_reg()));
    run_program();

    add_instr(gen_store());
    add_instr(gen_store());
    for (int i = 0; i < 24; i++)
      add_instr((i % 2) ? gen_load(5'd0) : gen_alu(5'd0));
    run_program();

    // Loads and ALU ops back to back so both units compete for the write port
    for (int i = 0; i < 150; i++)
    begin
      sel = next_rand() % 4;
      if (sel == 0)
        add_instr(gen_store());
      else if (sel == 1)
        add_instr(gen_load(pick_reg()));
      else
        add_instr(gen_alu(pick_reg()));
    end
    run_program();

    for (int i = 0; i < 100; i++)
    begin
      sel = next_rand() % 6;
      if (sel == 0)
        add_instr(gen_bad());
      else if (sel == 1)
        add_instr(gen_store());
      else if (sel == 2)
        add_instr(gen_load(pick_reg()));
      else
        add_instr(gen_alu(pick_reg()));
    end
    run_program();

    if (error_count == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
    begin
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule
